// ==== hw/tankGame_consts.svh ====
`ifndef TANKGAME_CONSTS_SVH
`define TANKGAME_CONSTS_SVH

// Visible screen area and coordinate width
`define PIXELS_HORIZ 640
`define PIXELS_VERT 480
`define COORD_W 10

// Map geometry, 32 pixel tiles on a 20 x 15 grid
`define TILE_SHIFT 5
`define MAP_COLS 20
`define MAP_ROWS 15

// Tank box spans TANK_WIDTH + 1 pixels per axis
`define TANK_WIDTH 25
`define TANK_START 5
`define EDGE_WIDTH 0
`define COIN_W 8

// Tile codes, wall and brick block the tank
`define TILE_EMPTY 4'd0
`define TILE_WALL 4'd1
`define TILE_BRICK 4'd2
`define TILE_COIN 4'd3

// Flat 12 bit colours as RGB nibbles
`define COLOUR_EMPTY 12'hEEE
`define COLOUR_WALL 12'h84C
`define COLOUR_BRICK 12'hC84
`define COLOUR_COIN 12'hFD0
// Codes 4 to 7
`define COLOUR_HAZARD 12'hF44
`define COLOUR_OTHER 12'h888
`define COLOUR_TANK 12'h0A0
`define COLOUR_BORDER 12'h222

////////////////////////////////////////////////////////////////////////////
// Reset layout, one nibble per tile, column 0 in the top nibble
////////////////////////////////////////////////////////////////////////////
`define MAP_ROW_0 80'h0000_0000_0000_0000_0000
`define MAP_ROW_1 80'h0232_3223_2332_3223_2320
`define MAP_ROW_2 80'h0332_3333_2332_3333_2330
`define MAP_ROW_3 80'h0222_2223_2332_3222_2220
`define MAP_ROW_4 80'h0332_3333_2332_3333_2330
`define MAP_ROW_5 80'h0232_3223_2222_3223_2330
`define MAP_ROW_6 80'h0333_3333_3333_3333_3330
`define MAP_ROW_7 80'h0222_2232_2222_2322_2220
`define MAP_ROW_8 80'h0333_3333_3333_3333_3330
`define MAP_ROW_9 80'h0232_3223_2222_3223_2320
`define MAP_ROW_10 80'h0332_3333_2332_3333_2330
`define MAP_ROW_11 80'h0222_2223_2332_3222_2220
`define MAP_ROW_12 80'h0332_3333_2332_3333_2330
`define MAP_ROW_13 80'h0232_3223_2332_3223_2320
`define MAP_ROW_14 80'h0000_0000_0000_0000_0000

`endif

// ==== hw/tankGame_pkg.sv ====
`default_nettype none

`include "tankGame_consts.svh"

package tankGame_pkg;

	// Screen position, used for the scan point and the tank's top left corner
	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} pixelPos_t;

	// Map cell address, col 0..19 and row 0..14
	typedef struct packed {
		logic [4:0] col;
		logic [3:0] row;
	} tileCoord_t;

	// One map nibble
	typedef logic [3:0] tileCode_t;

	////////////////////////////////////////////////////////////////////////////
	// Tank corners, always in the order TL, TR, BL, BR
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		tileCoord_t topLeft;
		tileCoord_t topRight;
		tileCoord_t bottomLeft;
		tileCoord_t bottomRight;
	} cornerTiles_t;

	typedef struct packed {
		tileCode_t topLeft;
		tileCode_t topRight;
		tileCode_t bottomLeft;
		tileCode_t bottomRight;
	} cornerCodes_t;

	// 4 bits per channel
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	// Request to empty one tile
	typedef struct packed {
		logic valid;
		tileCoord_t tile;
	} tileClear_t;

endpackage

`default_nettype wire

// ==== hw/tileMap.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tankGame_consts.svh"

module tileMap (
	input wire logic Master_Clock_In,
	input wire logic arstN,
	// Renderer lookup
	input wire tankGame_pkg::tileCoord_t pixelTile,
	output tankGame_pkg::tileCode_t pixelCode,
	// Tank corner lookups
	input wire tankGame_pkg::cornerTiles_t cornerTiles,
	output tankGame_pkg::cornerCodes_t cornerCodes,
	// Coin pickup write port
	input wire tankGame_pkg::tileClear_t tileClear
);

	// One 80 bit word per map row, column 0 in bits 79:76
	logic [`MAP_COLS*4-1:0] mapRow [`MAP_ROWS];

	// Pick the nibble of one tile out of its row word
	function automatic tankGame_pkg::tileCode_t readTile(input tankGame_pkg::tileCoord_t tile);
		logic [`MAP_COLS*4-1:0] rowBits;
		rowBits = mapRow[tile.row];
		return rowBits[(`MAP_COLS - 1 - tile.col) * 4 +: 4];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Read ports, all combinational
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// Pixel being drawn this cycle
		pixelCode = readTile(pixelTile);
		// Four tank corners for collision and pickup
		cornerCodes.topLeft = readTile(cornerTiles.topLeft);
		cornerCodes.topRight = readTile(cornerTiles.topRight);
		cornerCodes.bottomLeft = readTile(cornerTiles.bottomLeft);
		cornerCodes.bottomRight = readTile(cornerTiles.bottomRight);
	end

	////////////////////////////////////////////////////////////////////////////
	// Layout load and tile clear
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
		begin
			// Fresh level on every reset
			mapRow[0] <= `MAP_ROW_0;
			mapRow[1] <= `MAP_ROW_1;
			mapRow[2] <= `MAP_ROW_2;
			mapRow[3] <= `MAP_ROW_3;
			mapRow[4] <= `MAP_ROW_4;
			mapRow[5] <= `MAP_ROW_5;
			mapRow[6] <= `MAP_ROW_6;
			mapRow[7] <= `MAP_ROW_7;
			mapRow[8] <= `MAP_ROW_8;
			mapRow[9] <= `MAP_ROW_9;
			mapRow[10] <= `MAP_ROW_10;
			mapRow[11] <= `MAP_ROW_11;
			mapRow[12] <= `MAP_ROW_12;
			mapRow[13] <= `MAP_ROW_13;
			mapRow[14] <= `MAP_ROW_14;
		end
		else if (tileClear.valid)
		begin
			// Collected coin leaves an empty tile, whole nibble cleared
			mapRow[tileClear.tile.row][(`MAP_COLS - 1 - tileClear.tile.col) * 4 +: 4]
				<= `TILE_EMPTY;
		end
	end

endmodule

`default_nettype wire

// ==== hw/tankMotion.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tankGame_consts.svh"

module tankMotion (
	input wire logic Master_Clock_In,
	input wire logic arstN,
	input wire logic displayEnable,
	input wire tankGame_pkg::pixelPos_t scanPos,
	// Direction buttons
	input wire logic up,
	input wire logic down,
	input wire logic left,
	input wire logic right,
	// Corner lookups into the map
	output tankGame_pkg::cornerTiles_t cornerTiles,
	input wire tankGame_pkg::cornerCodes_t cornerCodes,
	output tankGame_pkg::tileClear_t tileClear,
	output tankGame_pkg::pixelPos_t tankPos,
	output logic [`COIN_W-1:0] coinCount
);

	// Pixel position to map cell, wrapping the grid
	function automatic tankGame_pkg::tileCoord_t toTile(input tankGame_pkg::pixelPos_t pos);
		tankGame_pkg::tileCoord_t tile;
		tile.col = 5'((pos.x >> `TILE_SHIFT) % `MAP_COLS);
		tile.row = 4'((pos.y >> `TILE_SHIFT) % `MAP_ROWS);
		return tile;
	endfunction

	// Wall and brick stop the tank
	function automatic logic isBlocking(input tankGame_pkg::tileCode_t code);
		return (code == `TILE_WALL) || (code == `TILE_BRICK);
	endfunction

	logic frameStep;
	tankGame_pkg::pixelPos_t wrapPos;
	tankGame_pkg::pixelPos_t stepPos;
	// Per corner flags, bit 0 TL, 1 TR, 2 BL, 3 BR
	logic [3:0] blockHit;
	logic [3:0] coinHit;
	logic pickup;
	tankGame_pkg::tileCoord_t pickupTile;

	// One update per frame, at the first pixel past the visible area
	assign frameStep = displayEnable && (scanPos.x == `PIXELS_HORIZ)
		&& (scanPos.y == `PIXELS_VERT);

	////////////////////////////////////////////////////////////////////////////
	// Edge wrap, evaluated before anything else
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		wrapPos = tankPos;
		// Top edge to bottom and back
		if (tankPos.y == `EDGE_WIDTH)
			wrapPos.y = 10'(`PIXELS_VERT - `TANK_WIDTH - 1);
		else if (tankPos.y == `PIXELS_VERT - `TANK_WIDTH - `EDGE_WIDTH)
			wrapPos.y = 10'd1;
		// Same for left and right
		if (tankPos.x == `EDGE_WIDTH)
			wrapPos.x = 10'(`PIXELS_HORIZ - `TANK_WIDTH - 1);
		else if (tankPos.x == `PIXELS_HORIZ - `TANK_WIDTH - `EDGE_WIDTH)
			wrapPos.x = 10'd1;
	end

	// Corner cells of the wrapped tank box
	assign cornerTiles.topLeft = toTile(wrapPos);
	assign cornerTiles.topRight = toTile({wrapPos.x + 10'(`TANK_WIDTH), wrapPos.y});
	assign cornerTiles.bottomLeft = toTile({wrapPos.x, wrapPos.y + 10'(`TANK_WIDTH)});
	assign cornerTiles.bottomRight = toTile({wrapPos.x + 10'(`TANK_WIDTH),
		wrapPos.y + 10'(`TANK_WIDTH)});

	assign blockHit = {isBlocking(cornerCodes.bottomRight), isBlocking(cornerCodes.bottomLeft),
		isBlocking(cornerCodes.topRight), isBlocking(cornerCodes.topLeft)};
	assign coinHit = {cornerCodes.bottomRight == `TILE_COIN, cornerCodes.bottomLeft == `TILE_COIN,
		cornerCodes.topRight == `TILE_COIN, cornerCodes.topLeft == `TILE_COIN};

	////////////////////////////////////////////////////////////////////////////
	// Next position: pushback, then pickup, then buttons
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stepPos = wrapPos;
		pickup = 1'b0;
		pickupTile = cornerTiles.topLeft;
		// Flat side against a block, push straight out
		if (blockHit[2] && blockHit[3])
			stepPos.y = wrapPos.y - 10'd1;
		else if (blockHit[0] && blockHit[2])
			stepPos.x = wrapPos.x + 10'd1;
		else if (blockHit[0] && blockHit[1])
			stepPos.y = wrapPos.y + 10'd1;
		else if (blockHit[1] && blockHit[3])
			stepPos.x = wrapPos.x - 10'd1;
		// Single corner inside, back off diagonally
		else if (blockHit[0])
		begin
			stepPos.x = wrapPos.x + 10'd1;
			stepPos.y = wrapPos.y + 10'd1;
		end
		else if (blockHit[1])
		begin
			stepPos.x = wrapPos.x - 10'd1;
			stepPos.y = wrapPos.y + 10'd1;
		end
		else if (blockHit[2])
		begin
			stepPos.x = wrapPos.x + 10'd1;
			stepPos.y = wrapPos.y - 10'd1;
		end
		else if (blockHit[3])
		begin
			stepPos.x = wrapPos.x - 10'd1;
			stepPos.y = wrapPos.y - 10'd1;
		end
		// Coin under a corner, first one in corner order wins
		else if (|coinHit)
		begin
			pickup = 1'b1;
			if (coinHit[0])
				pickupTile = cornerTiles.topLeft;
			else if (coinHit[1])
				pickupTile = cornerTiles.topRight;
			else if (coinHit[2])
				pickupTile = cornerTiles.bottomLeft;
			else
				pickupTile = cornerTiles.bottomRight;
		end
		// Free to drive, one pixel with priority up, right, down, left
		else if (up)
			stepPos.y = wrapPos.y - 10'd1;
		else if (right)
			stepPos.x = wrapPos.x + 10'd1;
		else if (down)
			stepPos.y = wrapPos.y + 10'd1;
		else if (left)
			stepPos.x = wrapPos.x - 10'd1;
	end

	// Map clears on the same edge as the step
	assign tileClear.valid = frameStep && pickup;
	assign tileClear.tile = pickupTile;

	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
		begin
			tankPos.x <= 10'(`TANK_START);
			tankPos.y <= 10'(`TANK_START);
			coinCount <= '0;
		end
		else if (frameStep)
		begin
			tankPos <= stepPos;
			// Count wraps at 256
			if (pickup)
				coinCount <= coinCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pixelRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tankGame_consts.svh"

module pixelRenderer (
	input wire logic Master_Clock_In,
	input wire logic arstN,
	input wire logic displayEnable,
	input wire tankGame_pkg::pixelPos_t scanPos,
	input wire tankGame_pkg::pixelPos_t tankPos,
	// Map lookup for the current pixel
	output tankGame_pkg::tileCoord_t pixelTile,
	input wire tankGame_pkg::tileCode_t pixelCode,
	output tankGame_pkg::rgb_t pixelColour
);

	logic outOfRange;
	logic inTank;
	// Far edges of the tank box, one bit wider so the sum never wraps
	logic [`COORD_W:0] tankRight;
	logic [`COORD_W:0] tankBottom;
	tankGame_pkg::rgb_t tileColour;
	tankGame_pkg::rgb_t nextColour;

	// Scan position to map cell, same wrap as the motion logic
	assign pixelTile.col = 5'((scanPos.x >> `TILE_SHIFT) % `MAP_COLS);
	assign pixelTile.row = 4'((scanPos.y >> `TILE_SHIFT) % `MAP_ROWS);

	assign outOfRange = (scanPos.x > `PIXELS_HORIZ) || (scanPos.y > `PIXELS_VERT);

	////////////////////////////////////////////////////////////////////////////
	// Tank box test, both edges inclusive
	////////////////////////////////////////////////////////////////////////////
	assign tankRight = {1'b0, tankPos.x} + 11'(`TANK_WIDTH);
	assign tankBottom = {1'b0, tankPos.y} + 11'(`TANK_WIDTH);
	assign inTank = (scanPos.x >= tankPos.x) && ({1'b0, scanPos.x} <= tankRight)
		&& (scanPos.y >= tankPos.y) && ({1'b0, scanPos.y} <= tankBottom);

	// Flat colour per tile code
	always_comb
	begin
		case (pixelCode)
			4'd0: tileColour = `COLOUR_EMPTY;
			4'd1: tileColour = `COLOUR_WALL;
			4'd2: tileColour = `COLOUR_BRICK;
			4'd3: tileColour = `COLOUR_COIN;
			4'd4, 4'd5, 4'd6, 4'd7: tileColour = `COLOUR_HAZARD;
			default: tileColour = `COLOUR_OTHER;
		endcase
	end

	// Priority: blanking, border, tank, then map
	always_comb
	begin
		if (!displayEnable)
			nextColour = '0;
		else if (outOfRange)
			nextColour = `COLOUR_BORDER;
		else if (inTank)
			nextColour = `COLOUR_TANK;
		else
			nextColour = tileColour;
	end

	// One cycle from scan position to colour
	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
			pixelColour <= '0;
		else
			pixelColour <= nextColour;
	end

endmodule

`default_nettype wire

// ==== hw/tankGameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tankGame_consts.svh"

module tankGameTop (
	input wire logic Master_Clock_In,
	input wire logic arstN,
	// Scan timing from the display controller
	input wire logic displayEnable,
	input wire tankGame_pkg::pixelPos_t scanPos,
	// Player buttons
	input wire logic up,
	input wire logic down,
	input wire logic left,
	input wire logic right,
	output tankGame_pkg::rgb_t pixelColour,
	output logic [`COIN_W-1:0] coinCount
);

	////////////////////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////////////////////
	tankGame_pkg::tileCoord_t pixelTile;
	tankGame_pkg::tileCode_t pixelCode;
	tankGame_pkg::cornerTiles_t cornerTiles;
	tankGame_pkg::cornerCodes_t cornerCodes;
	tankGame_pkg::tileClear_t tileClear;
	tankGame_pkg::pixelPos_t tankPos;

	// Level storage, shared by renderer and motion
	tileMap mapUnit (
		.Master_Clock_In(Master_Clock_In),
		.arstN(arstN),
		.pixelTile(pixelTile),
		.pixelCode(pixelCode),
		.cornerTiles(cornerTiles),
		.cornerCodes(cornerCodes),
		.tileClear(tileClear)
	);

	// Once per frame tank update and coin count
	tankMotion motionUnit (
		.Master_Clock_In(Master_Clock_In),
		.arstN(arstN),
		.displayEnable(displayEnable),
		.scanPos(scanPos),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.cornerTiles(cornerTiles),
		.cornerCodes(cornerCodes),
		.tileClear(tileClear),
		.tankPos(tankPos),
		.coinCount(coinCount)
	);

	// Per pixel colour
	pixelRenderer rendererUnit (
		.Master_Clock_In(Master_Clock_In),
		.arstN(arstN),
		.displayEnable(displayEnable),
		.scanPos(scanPos),
		.tankPos(tankPos),
		.pixelTile(pixelTile),
		.pixelCode(pixelCode),
		.pixelColour(pixelColour)
	);

endmodule

`default_nettype wire

// ==== tests/tankGame_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tankGame_consts.svh"

module tankGame_tb;

	// About 140 frames and 60 pixel reads at two cycles each, under 500 cycles
	localparam int timeoutCycles = 4000;
	// Button vectors in the order up, down, left, right
	localparam logic [3:0] btnNone = 4'b0000;
	localparam logic [3:0] btnDown = 4'b0100;
	localparam logic [3:0] btnLeft = 4'b0010;
	localparam logic [3:0] btnRight = 4'b0001;

	logic Master_Clock_In;
	logic arstN;
	logic displayEnable;
	tankGame_pkg::pixelPos_t scanPos;
	logic up;
	logic down;
	logic left;
	logic right;
	tankGame_pkg::rgb_t pixelColour;
	logic [`COIN_W-1:0] coinCount;

	// Reference model of map, tank and coin counter
	tankGame_pkg::tileCode_t modelMap [`MAP_ROWS][`MAP_COLS];
	int modelX;
	int modelY;
	logic [`COIN_W-1:0] modelCoins;
	logic [15:0] lfsrState;
	int cycleCount = 0;
	int errorCount;
	int testsFailed;
	string testName;

	tankGameTop UUT (
		.Master_Clock_In(Master_Clock_In),
		.arstN(arstN),
		.displayEnable(displayEnable),
		.scanPos(scanPos),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.pixelColour(pixelColour),
		.coinCount(coinCount)
	);

	// 40 ns period
	initial
	begin
		Master_Clock_In = 1'b0;
		forever #20 Master_Clock_In = ~Master_Clock_In;
	end

	always @(posedge Master_Clock_In)
	begin
		cycleCount++;
		if (cycleCount == timeoutCycles)
		begin
			$display("Timeout: simulation still running after %0d clock cycles", timeoutCycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random pixels and model lookups
	////////////////////////////////////////////////////////////////////////////

	// 16 bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic int takeBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return value;
	endfunction

	// Map cell under a pixel, grid wraps on both axes
	function automatic tankGame_pkg::tileCode_t codeAt(input int x, input int y);
		return modelMap[4'((y >> `TILE_SHIFT) % `MAP_ROWS)][5'((x >> `TILE_SHIFT) % `MAP_COLS)];
	endfunction

	function automatic logic insideTank(input int x, input int y);
		return x >= modelX && x <= modelX + `TANK_WIDTH && y >= modelY
			&& y <= modelY + `TANK_WIDTH;
	endfunction

	function automatic tankGame_pkg::rgb_t expectedColour(input int x, input int y, input logic en);
		if (!en)
			return '0;
		if (x > `PIXELS_HORIZ || y > `PIXELS_VERT)
			return `COLOUR_BORDER;
		if (insideTank(x, y))
			return `COLOUR_TANK;
		case (codeAt(x, y))
			`TILE_EMPTY: return `COLOUR_EMPTY;
			`TILE_WALL: return `COLOUR_WALL;
			`TILE_BRICK: return `COLOUR_BRICK;
			`TILE_COIN: return `COLOUR_COIN;
			4'd4, 4'd5, 4'd6, 4'd7: return `COLOUR_HAZARD;
			default: return `COLOUR_OTHER;
		endcase
	endfunction

	// Lowest set corner flag, TL first
	function automatic int firstCorner(input logic [3:0] flags);
		int hit;
		hit = 3;
		for (int i = 3; i >= 0; i--)
			if (flags[2'(i)])
				hit = i;
		return hit;
	endfunction

	task automatic loadLayout();
		logic [`MAP_COLS*4-1:0] layout [`MAP_ROWS];
		layout = '{`MAP_ROW_0, `MAP_ROW_1, `MAP_ROW_2, `MAP_ROW_3, `MAP_ROW_4, `MAP_ROW_5,
			`MAP_ROW_6, `MAP_ROW_7, `MAP_ROW_8, `MAP_ROW_9, `MAP_ROW_10, `MAP_ROW_11,
			`MAP_ROW_12, `MAP_ROW_13, `MAP_ROW_14};
		// Column 0 sits in the top nibble
		for (int r = 0; r < `MAP_ROWS; r++)
			for (int c = 0; c < `MAP_COLS; c++)
				modelMap[4'(r)][5'(c)] = 4'(layout[4'(r)] >> ((`MAP_COLS - 1 - c) * 4));
		modelX = `TANK_START;
		modelY = `TANK_START;
		modelCoins = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One frame of the model: wrap, pushback, coin, buttons
	////////////////////////////////////////////////////////////////////////////
	task automatic modelFrame(input logic [3:0] buttons);
		int wx;
		int wy;
		int hit;
		int cx [4];
		int cy [4];
		logic [3:0] blocked;
		logic [3:0] coin;
		wx = modelX;
		wy = modelY;
		if (wy == 0)
			wy = `PIXELS_VERT - `TANK_WIDTH - 1;
		else if (wy == `PIXELS_VERT - `TANK_WIDTH)
			wy = 1;
		if (wx == 0)
			wx = `PIXELS_HORIZ - `TANK_WIDTH - 1;
		else if (wx == `PIXELS_HORIZ - `TANK_WIDTH)
			wx = 1;
		// Corners TL, TR, BL, BR
		cx = '{wx, wx + `TANK_WIDTH, wx, wx + `TANK_WIDTH};
		cy = '{wy, wy, wy + `TANK_WIDTH, wy + `TANK_WIDTH};
		for (int i = 0; i < 4; i++)
		begin
			blocked[2'(i)] = codeAt(cx[i], cy[i]) == `TILE_WALL
				|| codeAt(cx[i], cy[i]) == `TILE_BRICK;
			coin[2'(i)] = codeAt(cx[i], cy[i]) == `TILE_COIN;
		end
		if (blocked[2] && blocked[3])
			wy--;
		else if (blocked[0] && blocked[2])
			wx++;
		else if (blocked[0] && blocked[1])
			wy++;
		else if (blocked[1] && blocked[3])
			wx--;
		else if (blocked != 4'b0)
		begin
			// Lone corner, away from it on both axes
			hit = firstCorner(blocked);
			wx += (hit % 2 == 0) ? 1 : -1;
			wy += (hit < 2) ? 1 : -1;
		end
		else if (coin != 4'b0)
		begin
			hit = firstCorner(coin);
			modelMap[4'((cy[hit] >> `TILE_SHIFT) % `MAP_ROWS)]
				[5'((cx[hit] >> `TILE_SHIFT) % `MAP_COLS)] = `TILE_EMPTY;
			modelCoins = modelCoins + 1'b1;
		end
		// Priority up, right, down, left
		else if (buttons[3])
			wy--;
		else if (buttons[0])
			wx++;
		else if (buttons[2])
			wy++;
		else if (buttons[1])
			wx--;
		modelX = wx;
		modelY = wy;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic driveInputs(input int x, input int y, input logic en, input logic [3:0] buttons);
		@(posedge Master_Clock_In);
		#2;
		scanPos.x = 10'(x);
		scanPos.y = 10'(y);
		displayEnable = en;
		{up, down, left, right} = buttons;
	endtask

	// Step position for exactly one edge
	task automatic frameStep(input logic [3:0] buttons);
		driveInputs(`PIXELS_HORIZ, `PIXELS_VERT, 1'b1, buttons);
		driveInputs(0, 0, 1'b1, btnNone);
		modelFrame(buttons);
	endtask

	// Colour is registered, read it one edge later
	task automatic samplePixel(input int x, input int y, input logic en,
		output tankGame_pkg::rgb_t colour);
		driveInputs(x, y, en, btnNone);
		@(posedge Master_Clock_In);
		#1;
		colour = pixelColour;
	endtask

	task automatic checkColour(input tankGame_pkg::rgb_t actual, input tankGame_pkg::rgb_t expected,
		input string what);
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error %s: %s expected %03h, actual %03h", testName, what, expected, actual);
		end
	endtask

	task automatic checkCoins(input logic [`COIN_W-1:0] actual, input logic [`COIN_W-1:0] expected,
		input string what);
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error %s: %s expected %0d, actual %0d", testName, what, expected, actual);
		end
	endtask

	task automatic checkPixel(input int x, input int y, input logic en,
		input tankGame_pkg::rgb_t expected);
		tankGame_pkg::rgb_t actual;
		samplePixel(x, y, en, actual);
		checkColour(actual, expected, $sformatf("pixel (%0d,%0d)", x, y));
	endtask

	// Box corners plus the pixel just left of the box
	task automatic checkTankBox();
		checkPixel(modelX, modelY, 1'b1, `COLOUR_TANK);
		checkPixel(modelX + `TANK_WIDTH, modelY + `TANK_WIDTH, 1'b1, `COLOUR_TANK);
		if (modelX > 0)
			checkPixel(modelX - 1, modelY, 1'b1, expectedColour(modelX - 1, modelY, 1'b1));
	endtask

	task automatic endTest(input int errorsBefore);
		if (errorCount == errorsBefore)
			$display("Test %s: passed", testName);
		else
		begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", testName, errorCount - errorsBefore);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests, run in order on one shared game state
	////////////////////////////////////////////////////////////////////////////
	task automatic testBlankingBorder();
		int errorsBefore;
		errorsBefore = errorCount;
		testName = "blankingBorder";
		checkPixel(200, 200, 1'b0, '0);
		checkPixel(10, 10, 1'b0, '0);
		checkPixel(700, 100, 1'b1, `COLOUR_BORDER);
		endTest(errorsBefore);
	endtask

	task automatic testMapRendering();
		int errorsBefore;
		int picked;
		int tries;
		int px;
		int py;
		errorsBefore = errorCount;
		testName = "mapRendering";
		picked = 0;
		tries = 0;
		while (picked < 12 && tries < 64)
		begin
			tries++;
			px = (takeBits(5) % `MAP_COLS) << `TILE_SHIFT;
			px += takeBits(5);
			py = (takeBits(4) % `MAP_ROWS) << `TILE_SHIFT;
			py += takeBits(5);
			// Tank would hide the tile
			if (!insideTank(px, py))
			begin
				checkPixel(px, py, 1'b1, expectedColour(px, py, 1'b1));
				picked++;
			end
		end
		if (picked < 12)
		begin
			errorCount++;
			$display("%s: only %0d pixels clear of the tank were found", testName, picked);
		end
		endTest(errorsBefore);
	endtask

	task automatic testTankMovement();
		int errorsBefore;
		errorsBefore = errorCount;
		testName = "tankMovement";
		checkPixel(10, 10, 1'b1, `COLOUR_TANK);
		repeat (20) frameStep(btnRight);
		checkTankBox();
		checkPixel(modelX - 1, modelY + `TANK_WIDTH, 1'b1,
			expectedColour(modelX - 1, modelY + `TANK_WIDTH, 1'b1));
		endTest(errorsBefore);
	endtask

	task automatic testEdgeWrap();
		int errorsBefore;
		int frames;
		errorsBefore = errorCount;
		testName = "edgeWrap";
		frames = 0;
		while (modelX != 0 && frames < 40)
		begin
			frameStep(btnLeft);
			frames++;
		end
		checkTankBox();
		// Next left frame lands on the far side
		frameStep(btnLeft);
		checkTankBox();
		checkPixel(0, modelY, 1'b1, expectedColour(0, modelY, 1'b1));
		endTest(errorsBefore);
	endtask

	task automatic testCollisionPushback();
		int errorsBefore;
		int frames;
		errorsBefore = errorCount;
		testName = "collisionPushback";
		frames = 0;
		// Right side over brick column 1, left side over empty column 0
		while (modelX != 20 && frames < 60)
		begin
			frameStep(btnRight);
			frames++;
		end
		repeat (6) frameStep(btnDown);
		frameStep(btnNone);
		checkPixel(modelX + `TANK_WIDTH, modelY + `TANK_WIDTH, 1'b1, `COLOUR_TANK);
		checkPixel(modelX + `TANK_WIDTH, modelY + `TANK_WIDTH + 1, 1'b1, `COLOUR_BRICK);
		endTest(errorsBefore);
	endtask

	task automatic testCoinPickup();
		int errorsBefore;
		int frames;
		errorsBefore = errorCount;
		testName = "coinPickup";
		frames = 0;
		while (modelX != 66 && frames < 80)
		begin
			frameStep(btnRight);
			frames++;
		end
		frames = 0;
		while (modelCoins == 0 && frames < 20)
		begin
			frameStep(btnDown);
			checkCoins(coinCount, modelCoins, "count while descending");
			frames++;
		end
		// Cleared tile must not pay out again
		repeat (8)
		begin
			frameStep(btnDown);
			checkCoins(coinCount, modelCoins, "count after pickup");
		end
		checkCoins(coinCount, 8'd1, "final count");
		checkPixel(94, 60, 1'b1, `COLOUR_EMPTY);
		endTest(errorsBefore);
	endtask

	initial
	begin
		arstN = 1'b0;
		displayEnable = 1'b0;
		scanPos = '0;
		{up, down, left, right} = btnNone;
		errorCount = 0;
		testsFailed = 0;
		lfsrState = 16'd64;
		loadLayout();
		repeat (10) @(posedge Master_Clock_In);
		#2;
		arstN = 1'b1;
		testBlankingBorder();
		testMapRendering();
		testTankMovement();
		testEdgeWrap();
		testCollisionPushback();
		testCoinPickup();
		$display("Tests run: 6, tests failed: %0d, failed checks: %0d", testsFailed, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/tankGame_pkg.sv
hw/tileMap.sv
hw/tankMotion.sv
hw/pixelRenderer.sv
hw/tankGameTop.sv
tests/tankGame_tb.sv

// ==== Makefile ====
SIM := obj_dir/tankGameSim

.PHONY: all run lint clean

all: run

$(SIM): sim.f hw/*.sv hw/*.svh tests/*.sv
	verilator --binary --timing -j 0 -f sim.f --top-module tankGame_tb -o tankGameSim

# Pass only when the testbench prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tankGameTop

clean:
	rm -rf obj_dir
